/* rtl/endpoint_pkg.sv */
// Shared types and constants for the endpoint register bridge
// Imported by the decoder, the framer and the testbench
`default_nettype none

package endpoint_pkg;

	// ----------------------------------------
	// Byte format
	// ----------------------------------------

	// One FT245 transfer word
	localparam int BYTE_W = 8;

	// Control byte fields, tag on top then command then address
	localparam int TAG_W  = 2;
	localparam int CMD_W  = 3;
	localparam int ADDR_W = 3;

	// Tag of a host-to-device control byte
	localparam logic [TAG_W-1:0] TAG_RX = 2'b10;
	// Tag of a device-to-host header byte
	localparam logic [TAG_W-1:0] TAG_TX = 2'b11;

	// ----------------------------------------
	// Commands
	// ----------------------------------------

	// Codes 3, 6 and 7 are not supported
	typedef enum logic [CMD_W-1:0]
	{
		cmd_none         = 3'd0,
		cmd_trigger_in   = 3'd1,
		cmd_transfer_in  = 3'd2,
		cmd_trigger_out  = 3'd4,
		cmd_transfer_out = 3'd5
	} cmd_e;

	// Host-to-device commands the decoder turns into messages
	function automatic logic is_in_cmd(input cmd_e cmd);
		return (cmd == cmd_trigger_in) || (cmd == cmd_transfer_in);
	endfunction

	// Device-to-host commands the framer sends as two bytes
	function automatic logic is_out_cmd(input cmd_e cmd);
		return (cmd == cmd_trigger_out) || (cmd == cmd_transfer_out);
	endfunction

	// ----------------------------------------
	// User-side messages
	// ----------------------------------------

	// Device-bound message, all zero when valid is low
	typedef struct packed
	{
		logic              valid;
		cmd_e              command;
		logic [ADDR_W-1:0] address;
		logic [BYTE_W-1:0] payload;
	} uc_in_t;

	// Host-bound request from the device logic
	typedef struct packed
	{
		cmd_e              command;
		logic [ADDR_W-1:0] address;
		logic [BYTE_W-1:0] payload;
	} uc_out_t;

endpackage

`default_nettype wire

/* rtl/host_rx_decoder.sv */
// Host-to-device side: reads a control byte and a data byte from the FT245 port
// and presents one message on uc_in for a single cycle
`default_nettype none
`timescale 1ns/100ps

module host_rx_decoder
(
	input  wire                              CLK,
	input  wire                              RST_N,
	input  wire [endpoint_pkg::BYTE_W-1:0]   endpoint_decode,
	input  wire                              data_byte_ready,
	output logic                             endpoint_en,
	output endpoint_pkg::uc_in_t             uc_in
);

	import endpoint_pkg::*;

	// Receive FSM states
	typedef enum logic [2:0]
	{
		rx_idle,
		rx_decode,
		rx_read_ctrl,
		rx_read_data,
		rx_emit
	} rx_state_e;

	rx_state_e state;
	rx_state_e state_nxt;

	// Pending control byte
	logic              pend_valid;
	cmd_e              pend_cmd;
	logic [ADDR_W-1:0] pend_addr;

	// Data byte held for the emit cycle
	logic [BYTE_W-1:0] data_q;

	// Byte on the port carries the host-to-device tag
	logic              is_ctrl;
	// Emit cycle with a supported command
	logic              msg_ok;

	assign is_ctrl = (endpoint_decode[BYTE_W-1 -: TAG_W] == TAG_RX);

	// ----------------------------------------
	// State machine
	// ----------------------------------------

	always_ff @(posedge CLK or negedge RST_N)
	begin
		if (!RST_N)
			state <= rx_idle;
		else
			state <= state_nxt;
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			rx_idle:
			begin
				// Wait here as long as the FT side holds off
				if (data_byte_ready)
					state_nxt = rx_decode;
			end
			rx_decode:
			begin
				if (is_ctrl)
					state_nxt = rx_read_ctrl;
				else if (pend_valid)
					state_nxt = rx_read_data;
				else
					// Stray byte, drained without being stored
					state_nxt = rx_read_ctrl;
			end
			rx_read_ctrl:
			begin
				if (!data_byte_ready)
					state_nxt = rx_idle;
			end
			rx_read_data:
			begin
				// Transfer cycle goes straight to emit
				if (data_byte_ready)
					state_nxt = rx_emit;
				else
					state_nxt = rx_idle;
			end
			rx_emit:
				state_nxt = rx_idle;
			default:
				state_nxt = rx_idle;
		endcase
	end

	// Handshake back to the FT side
	assign endpoint_en = (state == rx_read_ctrl) || (state == rx_read_data);

	// ----------------------------------------
	// Pending control and data capture
	// ----------------------------------------

	always_ff @(posedge CLK or negedge RST_N)
	begin
		if (!RST_N)
			pend_valid <= 1'b0;
		else if (state == rx_decode && is_ctrl)
			pend_valid <= 1'b1;
		else if (state == rx_emit)
			pend_valid <= 1'b0;
	end

	always_ff @(posedge CLK)
	begin
		if (state == rx_decode && is_ctrl)
		begin
			pend_cmd  <= cmd_e'(endpoint_decode[ADDR_W +: CMD_W]);
			pend_addr <= endpoint_decode[ADDR_W-1:0];
		end
		// Data byte taken on its transfer cycle
		if (state == rx_read_data && data_byte_ready)
			data_q <= endpoint_decode;
	end

	// ----------------------------------------
	// User-side message
	// ----------------------------------------

	assign msg_ok = (state == rx_emit) && pend_valid && is_in_cmd(pend_cmd);

	always_comb
	begin
		uc_in = '0;
		if (msg_ok)
		begin
			uc_in.valid   = 1'b1;
			uc_in.command = pend_cmd;
			// Trigger in carries no address
			uc_in.address = (pend_cmd == cmd_transfer_in) ? pend_addr : '0;
			uc_in.payload = data_q;
		end
	end

	// ----------------------------------------
	// Checks
	// ----------------------------------------

	// One message per data byte
	a_valid_single: assert property (@(posedge CLK) disable iff (!RST_N)
		uc_in.valid |=> !uc_in.valid);

	// endpoint_en follows data_byte_ready down within a cycle
	a_en_release: assert property (@(posedge CLK) disable iff (!RST_N)
		(endpoint_en && !data_byte_ready) |=> !endpoint_en);

endmodule

`default_nettype wire

/* rtl/host_tx_framer.sv */
// Device-to-host side: captures a request from uc_out and writes a header byte
// and a payload byte to the FT245 port, deferring while the FT side is busy
`default_nettype none
`timescale 1ns/100ps

module host_tx_framer
(
	input  wire                              CLK,
	input  wire                              RST_N,
	input  endpoint_pkg::uc_out_t            uc_out,
	input  wire                              ft_busy,
	input  wire                              write_ready,
	input  wire                              write_complete,
	output logic                             write_en,
	output logic [endpoint_pkg::BYTE_W-1:0]  write_byte,
	output logic                             busy
);

	import endpoint_pkg::*;

	// Transmit FSM states
	typedef enum logic [2:0]
	{
		tx_idle,
		tx_wait_free,
		tx_write,
		tx_wait_complete,
		tx_next
	} tx_state_e;

	tx_state_e state;
	tx_state_e state_nxt;

	// Previous command for edge detection
	cmd_e              prev_cmd;

	// Latched request
	cmd_e              req_cmd;
	logic [ADDR_W-1:0] req_addr;
	logic [BYTE_W-1:0] req_payload;

	// 0 for the header, 1 for the payload
	logic              byte_idx;

	// New out request while idle
	logic              capture;

	// Check only: write accepted, write_complete still owed
	logic              chk_await_complete;

	// ----------------------------------------
	// Request capture
	// ----------------------------------------

	always_ff @(posedge CLK or negedge RST_N)
	begin
		if (!RST_N)
			prev_cmd <= cmd_none;
		else
			prev_cmd <= uc_out.command;
	end

	// Rising edge from cmd_none to an out command, in-commands ignored
	assign capture = (state == tx_idle) && (prev_cmd == cmd_none) &&
		is_out_cmd(uc_out.command);

	// Device may drop the request once it is latched
	always_ff @(posedge CLK)
	begin
		if (capture)
		begin
			req_cmd     <= uc_out.command;
			req_addr    <= uc_out.address;
			req_payload <= uc_out.payload;
		end
	end

	// ----------------------------------------
	// State machine
	// ----------------------------------------

	always_ff @(posedge CLK or negedge RST_N)
	begin
		if (!RST_N)
		begin
			state    <= tx_idle;
			byte_idx <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			if (capture)
				byte_idx <= 1'b0;
			else if (state == tx_next)
				byte_idx <= !byte_idx;
		end
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			tx_idle:
			begin
				// Defer the start while the FT side is reading
				if (capture)
					state_nxt = ft_busy ? tx_wait_free : tx_write;
			end
			tx_wait_free:
			begin
				if (!ft_busy)
					state_nxt = tx_write;
			end
			tx_write:
			begin
				if (write_ready)
					state_nxt = tx_wait_complete;
			end
			tx_wait_complete:
			begin
				if (write_complete)
					state_nxt = tx_next;
			end
			tx_next:
				// Header done, go again for the payload
				state_nxt = byte_idx ? tx_idle : tx_write;
			default:
				state_nxt = tx_idle;
		endcase
	end

	// ----------------------------------------
	// Byte port outputs
	// ----------------------------------------

	assign write_en   = (state == tx_write);
	assign write_byte = byte_idx ? req_payload : {TAG_TX, req_cmd, req_addr};

	// Low again once the payload write_complete has been seen
	assign busy = (state != tx_idle) && !(state == tx_next && byte_idx);

	// ----------------------------------------
	// Checks
	// ----------------------------------------

	always_ff @(posedge CLK or negedge RST_N)
	begin
		if (!RST_N)
			chk_await_complete <= 1'b0;
		else if (write_en && write_ready)
			chk_await_complete <= 1'b1;
		else if (write_complete)
			chk_await_complete <= 1'b0;
	end

	// Byte held under back-pressure
	a_byte_hold: assert property (@(posedge CLK) disable iff (!RST_N)
		(write_en && !write_ready) |=> (write_en && $stable(write_byte)));

	// Next byte only after the FT side finished the last one
	a_no_early_write: assert property (@(posedge CLK) disable iff (!RST_N)
		$rose(write_en) |-> !chk_await_complete);

endmodule

`default_nettype wire

/* rtl/endpoint_top.sv */
// Endpoint register bridge between an FT245 byte port and the user registers
// Receive and transmit directions run as two independent FSMs
`default_nettype none
`timescale 1ns/100ps

module endpoint_top
(
	input  wire                              CLK,
	input  wire                              RST_N,

	// FT245 receive side
	input  wire [endpoint_pkg::BYTE_W-1:0]   endpoint_decode,
	input  wire                              data_byte_ready,
	output logic                             endpoint_en,

	// FT245 write side
	input  wire                              ft_busy,
	input  wire                              write_ready,
	input  wire                              write_complete,
	output logic                             write_en,
	output logic [endpoint_pkg::BYTE_W-1:0]  write_byte,
	output logic                             endpoint_busy,

	// User side
	input  endpoint_pkg::uc_out_t            uc_out,
	output endpoint_pkg::uc_in_t             uc_in,
	output logic                             uc_in_busy
);

	// Transmit transaction in progress
	logic tx_busy;

	// Host-to-device decoder
	host_rx_decoder i_rx
	(
		.CLK             (CLK),
		.RST_N           (RST_N),
		.endpoint_decode (endpoint_decode),
		.data_byte_ready (data_byte_ready),
		.endpoint_en     (endpoint_en),
		.uc_in           (uc_in)
	);

	// Device-to-host framer
	host_tx_framer i_tx
	(
		.CLK            (CLK),
		.RST_N          (RST_N),
		.uc_out         (uc_out),
		.ft_busy        (ft_busy),
		.write_ready    (write_ready),
		.write_complete (write_complete),
		.write_en       (write_en),
		.write_byte     (write_byte),
		.busy           (tx_busy)
	);

	// FT side arbitrates on this, device logic sees the same flag
	assign endpoint_busy = tx_busy;
	assign uc_in_busy    = tx_busy;

endmodule

`default_nettype wire

/* bench/ft245_host_model.sv */
// FT245-side model for the endpoint testbench
// Feeds queued receive bytes and answers DUT writes after the given delays
`default_nettype none
`timescale 1ns/100ps

module ft245_host_model
(
	input  wire                              CLK,
	input  wire                              rx_push,
	input  wire [endpoint_pkg::BYTE_W-1:0]   rx_byte,
	input  wire [2:0]                        gap_delay,
	input  wire [2:0]                        wr_delay,
	input  wire                              endpoint_en,
	input  wire                              write_en,
	output logic [endpoint_pkg::BYTE_W-1:0]  endpoint_decode,
	output logic                             data_byte_ready,
	output logic                             write_ready,
	output logic                             write_complete
);

	import endpoint_pkg::*;

	// Bytes waiting to go to the DUT
	logic [BYTE_W-1:0] rx_q[$];

	logic [2:0] gap_cnt;
	// 0 idle, 1 ready delay, 2 complete delay
	logic [1:0] wr_phase;
	logic [2:0] wr_cnt;

	initial
	begin
		endpoint_decode = '0;
		data_byte_ready = 1'b0;
		write_ready     = 1'b0;
		write_complete  = 1'b0;
		gap_cnt         = '0;
		wr_phase        = '0;
		wr_cnt          = '0;
	end

	// ----------------------------------------
	// Receive bytes
	// ----------------------------------------

	always @(posedge CLK)
	begin
		if (rx_push)
			rx_q.push_back(rx_byte);
		if (data_byte_ready && endpoint_en)
		begin
			// Byte taken, drop ready for at least one cycle
			data_byte_ready <= 1'b0;
			gap_cnt         <= gap_delay;
			void'(rx_q.pop_front());
		end
		else if (!data_byte_ready && rx_q.size() > 0)
		begin
			if (gap_cnt == 3'd0)
			begin
				endpoint_decode <= rx_q[0];
				data_byte_ready <= 1'b1;
			end
			else
				gap_cnt <= gap_cnt - 3'd1;
		end
	end

	// ----------------------------------------
	// Write bytes
	// ----------------------------------------

	always @(posedge CLK)
	begin
		write_complete <= 1'b0;
		if (write_en && write_ready)
		begin
			write_ready <= 1'b0;
			wr_cnt      <= wr_delay;
			wr_phase    <= 2'd2;
		end
		else if (wr_phase == 2'd0 && write_en)
		begin
			wr_cnt   <= wr_delay;
			wr_phase <= 2'd1;
		end
		else if (wr_phase == 2'd1)
		begin
			if (wr_cnt == 3'd0)
				write_ready <= 1'b1;
			else
				wr_cnt <= wr_cnt - 3'd1;
		end
		else if (wr_phase == 2'd2)
		begin
			// One-cycle completion pulse
			if (wr_cnt == 3'd0)
			begin
				write_complete <= 1'b1;
				wr_phase       <= 2'd0;
			end
			else
				wr_cnt <= wr_cnt - 3'd1;
		end
	end

endmodule

`default_nettype wire

/* bench/endpoint_tb.sv */
// Testbench for the endpoint register bridge
// Drives both byte directions through the FT-side model, assertions do the checking
`default_nettype none
`timescale 1ns/100ps

module endpoint_tb;

	import endpoint_pkg::*;

	logic              CLK;
	logic              RST_N;
	logic              rx_push;
	logic [BYTE_W-1:0] rx_byte;
	logic [2:0]        gap_delay;
	logic [2:0]        wr_delay;
	logic              ft_busy;
	uc_out_t           uc_out;

	wire  [BYTE_W-1:0] endpoint_decode;
	wire               data_byte_ready;
	wire               write_ready;
	wire               write_complete;
	logic              endpoint_en;
	logic              endpoint_busy;
	logic              write_en;
	logic [BYTE_W-1:0] write_byte;
	uc_in_t            uc_in;
	logic              uc_in_busy;

	// Expected receive message
	uc_in_t            exp_in;
	logic              exp_in_pending;
	// Expected write bytes of the current request
	logic [BYTE_W-1:0] exp_wr_hdr;
	logic [BYTE_W-1:0] exp_wr_pay;
	logic [BYTE_W-1:0] exp_wr;
	int                wr_idx;
	int                wr_total;
	int                cmpl_cnt;
	int                rx_xfers;
	int                msgs_seen;
	int                err_value;
	int                err_event;
	logic [31:0]       lfsr = 32'h2764eed7;

	endpoint_top i_dut
	(
		.CLK(CLK), .RST_N(RST_N),
		.endpoint_decode(endpoint_decode), .data_byte_ready(data_byte_ready),
		.endpoint_en(endpoint_en),
		.ft_busy(ft_busy), .write_ready(write_ready), .write_complete(write_complete),
		.write_en(write_en), .write_byte(write_byte), .endpoint_busy(endpoint_busy),
		.uc_out(uc_out), .uc_in(uc_in), .uc_in_busy(uc_in_busy)
	);

	ft245_host_model i_host
	(
		.CLK(CLK), .rx_push(rx_push), .rx_byte(rx_byte),
		.gap_delay(gap_delay), .wr_delay(wr_delay),
		.endpoint_en(endpoint_en), .write_en(write_en),
		.endpoint_decode(endpoint_decode), .data_byte_ready(data_byte_ready),
		.write_ready(write_ready), .write_complete(write_complete)
	);

	initial
	begin
		CLK = 1'b0;
		forever
			#5 CLK = ~CLK;
	end

	// Galois LFSR, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r    = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return r;
	endfunction

	// Top bits 10 would read as a control byte
	function automatic logic [BYTE_W-1:0] rand_payload();
		logic [31:0] r;
		r = rand_bits(8);
		if (r[7:6] == TAG_RX)
			r[6] = 1'b1;
		return r[7:0];
	endfunction

	// Message the decoder should present for an in-command
	function automatic uc_in_t in_msg(input cmd_e c, input logic [2:0] a,
		input logic [BYTE_W-1:0] p);
		uc_in_t m;
		m.valid   = 1'b1;
		m.command = c;
		m.address = a;
		m.payload = p;
		return m;
	endfunction

	task automatic wait_clk(input int n);
		repeat (n) @(posedge CLK);
	endtask

	// ----------------------------------------
	// Event tracking and delays
	// ----------------------------------------

	assign exp_wr = (wr_idx == 0) ? exp_wr_hdr : exp_wr_pay;

	// Host delays for the coming cycles
	always @(negedge CLK)
	begin : delay_blk
		logic [31:0] rnd;
		rnd = rand_bits(6);
		gap_delay <= rnd[2:0];
		wr_delay  <= rnd[5:3];
	end

	always @(posedge CLK)
	begin : track_blk
		if (write_en && write_ready)
			wr_idx <= wr_idx + 1;
		if (write_complete)
			cmpl_cnt <= cmpl_cnt + 1;
		if (data_byte_ready && endpoint_en)
			rx_xfers <= rx_xfers + 1;
		if (uc_in.valid)
		begin
			msgs_seen      <= msgs_seen + 1;
			exp_in_pending <= 1'b0;
		end
	end

	// ----------------------------------------
	// Checks
	// ----------------------------------------

	a_reset: assert property (@(posedge CLK) $rose(RST_N) |->
		!(endpoint_en || write_en || endpoint_busy || uc_in_busy || uc_in.valid))
	else
	begin
		err_event++;
		$display("Outputs were not low right after reset at %0t", $time);
	end

	a_uc_in_idle: assert property (@(posedge CLK) disable iff (!RST_N)
		!uc_in.valid |-> (uc_in == '0))
	else
	begin
		err_value++;
		$display("FAILED %0t uc_in expected %h actual %h", $time, 15'h0, $sampled(uc_in));
	end

	a_uc_in_msg: assert property (@(posedge CLK) disable iff (!RST_N)
		uc_in.valid |-> (exp_in_pending && uc_in == exp_in))
	else
	begin
		err_value++;
		$display("FAILED %0t uc_in expected %h actual %h", $time,
			exp_in_pending ? $sampled(exp_in) : 15'h0, $sampled(uc_in));
	end

	a_write_byte: assert property (@(posedge CLK) disable iff (!RST_N)
		(write_en && write_ready) |-> (wr_idx < wr_total && write_byte == exp_wr))
	else
	begin
		err_value++;
		$display("FAILED %0t write_byte expected %h actual %h (byte %0d of %0d)", $time,
			$sampled(exp_wr), $sampled(write_byte), $sampled(wr_idx), $sampled(wr_total));
	end

	// Held byte under back-pressure
	a_write_hold: assert property (@(posedge CLK) disable iff (!RST_N)
		(write_en && !write_ready) |=> (write_en && $stable(write_byte)))
	else
	begin
		err_event++;
		$display("write_en or write_byte changed before write_ready at %0t", $time);
	end

	a_ft_busy: assert property (@(posedge CLK) disable iff (!RST_N)
		ft_busy |=> !$rose(write_en))
	else
	begin
		err_event++;
		$display("write_en rose while ft_busy was high at %0t", $time);
	end

	a_busy_end: assert property (@(posedge CLK) disable iff (!RST_N)
		$fell(endpoint_busy) |-> (cmpl_cnt == 2))
	else
	begin
		err_event++;
		$display("endpoint_busy fell after %0d write_complete pulses at %0t",
			$sampled(cmpl_cnt), $time);
	end

	a_busy_copy: assert property (@(posedge CLK) disable iff (!RST_N)
		uc_in_busy == endpoint_busy)
	else
	begin
		err_value++;
		$display("FAILED %0t uc_in_busy expected %b actual %b", $time,
			$sampled(endpoint_busy), $sampled(uc_in_busy));
	end

	// ----------------------------------------
	// Stimulus tasks
	// ----------------------------------------

	// Optional control byte, then a data byte
	task automatic rx_message(input logic has_ctrl, input logic [BYTE_W-1:0] ctrl,
		input logic [BYTE_W-1:0] data, input logic expect_msg, input uc_in_t msg);
		int target;
		int seen;
		int t;
		target = rx_xfers + (has_ctrl ? 2 : 1);
		seen   = msgs_seen;
		@(posedge CLK);
		exp_in         <= msg;
		exp_in_pending <= expect_msg;
		if (has_ctrl)
		begin
			rx_byte <= ctrl;
			rx_push <= 1'b1;
			@(posedge CLK);
		end
		rx_byte <= data;
		rx_push <= 1'b1;
		@(posedge CLK);
		rx_push <= 1'b0;
		t = 0;
		while (rx_xfers < target && t < 200)
		begin
			@(posedge CLK);
			t++;
		end
		if (rx_xfers < target)
		begin
			err_event++;
			$display("Receive bytes were not taken by the DUT at %0t", $time);
		end
		if (expect_msg)
		begin
			t = 0;
			while (msgs_seen == seen && t < 4)
			begin
				@(posedge CLK);
				t++;
			end
			if (msgs_seen == seen)
			begin
				err_event++;
				$display("No uc_in message after the data byte at %0t", $time);
			end
		end
		else
			wait_clk(3);
		exp_in_pending <= 1'b0;
	endtask

	// One uc_out request, optionally with ft_busy held at capture
	// expect_wr set when a header and a payload should go out
	task automatic tx_request(input cmd_e c, input logic [2:0] a,
		input logic [BYTE_W-1:0] p, input logic hold_busy, input logic expect_wr);
		logic [31:0] r;
		int          t;
		@(posedge CLK);
		exp_wr_hdr <= {TAG_TX, c, a};
		exp_wr_pay <= p;
		wr_idx     <= 0;
		wr_total   <= expect_wr ? 2 : 0;
		cmpl_cnt   <= 0;
		uc_out     <= '{command: c, address: a, payload: p};
		ft_busy    <= hold_busy;
		@(posedge CLK);
		uc_out <= '0;
		if (hold_busy)
		begin
			r = rand_bits(3);
			wait_clk(r[2:0] + 1);
			ft_busy <= 1'b0;
		end
		if (expect_wr)
		begin
			t = 0;
			while (!endpoint_busy && t < 16)
			begin
				@(posedge CLK);
				t++;
			end
			if (!endpoint_busy)
			begin
				err_event++;
				$display("endpoint_busy did not rise after the request at %0t", $time);
			end
			while (endpoint_busy && t < 64)
			begin
				@(posedge CLK);
				t++;
			end
			if (endpoint_busy || wr_idx != 2)
			begin
				err_event++;
				$display("Transmit transaction did not finish at %0t", $time);
			end
		end
		else
			wait_clk(4);
		wr_total <= 0;
	endtask

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------

	initial
	begin : main_blk
		logic [31:0]       r;
		logic [BYTE_W-1:0] p;
		logic [BYTE_W-1:0] p2;
		RST_N          = 1'b0;
		rx_push        = 1'b0;
		rx_byte        = '0;
		gap_delay      = '0;
		wr_delay       = '0;
		ft_busy        = 1'b0;
		uc_out         = '0;
		exp_in         = '0;
		exp_in_pending = 1'b0;
		exp_wr_hdr     = '0;
		exp_wr_pay     = '0;
		wr_idx         = 0;
		wr_total       = 0;
		cmpl_cnt       = 0;
		rx_xfers       = 0;
		msgs_seen      = 0;
		err_value      = 0;
		err_event      = 0;
		repeat (5) @(posedge CLK);
		RST_N <= 1'b1;
		wait_clk(2);

		// Stray data byte, then an unsupported command
		rx_message(1'b0, '0, 8'h3c, 1'b0, '0);
		rx_message(1'b1, {TAG_RX, 3'd3, 3'd5}, rand_payload(), 1'b0, '0);

		// Trigger in carries no address, whatever the control byte holds
		for (int i = 0; i < 8; i++)
		begin
			r = rand_bits(3);
			p = rand_payload();
			if (i < 4)
				rx_message(1'b1, {TAG_RX, cmd_trigger_in, r[2:0]}, p, 1'b1,
					in_msg(cmd_trigger_in, 3'd0, p));
			else
				rx_message(1'b1, {TAG_RX, cmd_transfer_in, r[2:0]}, p, 1'b1,
					in_msg(cmd_transfer_in, r[2:0], p));
		end

		for (int i = 0; i < 4; i++)
		begin
			r = rand_bits(3);
			tx_request((i % 2 == 0) ? cmd_trigger_out : cmd_transfer_out, r[2:0],
				rand_payload(), 1'b0, 1'b1);
		end
		// In-command on uc_out writes nothing
		tx_request(cmd_transfer_in, 3'd2, 8'h55, 1'b0, 1'b0);
		tx_request(cmd_trigger_out, 3'd1, rand_payload(), 1'b1, 1'b1);
		tx_request(cmd_transfer_out, 3'd6, rand_payload(), 1'b1, 1'b1);

		// Both directions at once
		for (int i = 0; i < 4; i++)
		begin
			r  = rand_bits(6);
			p  = rand_payload();
			p2 = rand_payload();
			fork
				tx_request(cmd_transfer_out, r[2:0], p, 1'b0, 1'b1);
				rx_message(1'b1, {TAG_RX, cmd_transfer_in, r[5:3]}, p2, 1'b1,
					in_msg(cmd_transfer_in, r[5:3], p2));
			join
		end

		wait_clk(4);
		$display("errors: %0d value mismatches, %0d protocol failures", err_value, err_event);
		if (err_value + err_event == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// Watchdog, 40 transactions of 64 cycles each
	initial
	begin
		repeat (40 * 64) @(posedge CLK);
		$display("Watchdog expired before the test sequence finished");
		$display("errors: %0d value mismatches, %0d protocol failures", err_value, err_event);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
rtl/endpoint_pkg.sv
rtl/host_rx_decoder.sv
rtl/host_tx_framer.sv
rtl/endpoint_top.sv
bench/ft245_host_model.sv
bench/endpoint_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the endpoint bridge testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module endpoint_tb -o endpoint_sim &&
	./obj_dir/endpoint_sim | tee /dev/stderr | grep -F -q '** PASS **' &&
	echo "simulation passed" && exit 0 ||
	{ echo "simulation failed"; exit 1; }
